// File: mips_decode_macros.svh
// width and register constants for the decode stage shared by the RTL and the testbench
`ifndef MIPS_DECODE_MACROS_SVH
`define MIPS_DECODE_MACROS_SVH

// machine word and address width
`define MIPS_XLEN 32

// general purpose register number width
`define REG_ADDR_W 5

// bytes per instruction
`define PC_STEP 4

// link register written by JAL, JALR and the REGIMM link branches
`define REG_RA 31

`endif

// File: decode_pkg.sv
// shared types for the decode stage with instruction layouts, operation codes and flow classes
`include "mips_decode_macros.svh"

package decode_pkg;

    typedef logic [`MIPS_XLEN-1:0]  virt_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_inst_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm16;
    } i_inst_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index26;
    } j_inst_t;

    // one word, three layouts
    typedef union packed {
        r_inst_t r;
        i_inst_t i;
        j_inst_t j;
    } inst_u;

    typedef enum logic [5:0] {
        OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_JALR, OP_SYSCALL, OP_BREAK,
        OP_MFHI, OP_MTHI, OP_MFLO, OP_MTLO,
        OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU, OP_LUI,
        OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL,
        OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_JAL,
        OP_MFC0, OP_MTC0, OP_ERET,
        OP_INVALID
    } op_t;

    typedef enum logic [2:0] {
        CF_NONE,
        CF_BRANCH,
        CF_JUMP,
        CF_CALL,
        CF_RETURN
    } cf_t;

endpackage

// File: decode_if.sv
// combinational decode result passed from the decode blocks into the stage register
`timescale 1ns/100ps

interface decode_if;

    decode_pkg::op_t       op;
    decode_pkg::reg_addr_t rs1;
    decode_pkg::reg_addr_t rs2;
    decode_pkg::reg_addr_t rd;
    logic                  use_imm;
    logic                  imm_signed;
    logic                  is_load;
    logic                  is_store;
    decode_pkg::cf_t       cf;
    logic                  is_controlflow;
    decode_pkg::virt_t     jump_i;
    decode_pkg::virt_t     jump_j;

    modport dec (output op, rs1, rs2, rd, use_imm, imm_signed, is_load, is_store);
    modport cls (output cf, is_controlflow);
    modport tgt (output jump_i, jump_j);
    modport sink (input op, rs1, rs2, rd, use_imm, imm_signed, is_load, is_store,
                  cf, is_controlflow, jump_i, jump_j);

endinterface

// File: branch_classifier.sv
// finds branches, jumps, calls and returns in an instruction and gives its control-flow class
`timescale 1ns/100ps
`include "mips_decode_macros.svh"

module branch_classifier (
    input decode_pkg::inst_u inst,
    decode_if.cls            cls
);

    logic is_special;
    logic is_regimm_br;
    logic is_branch;
    logic is_jump_i;
    logic is_jump_r;
    logic is_call;
    logic is_return;

    assign is_special   = (inst.r.opcode == 6'b000000);
    assign is_regimm_br = (inst.i.opcode == 6'b000001) && (inst.i.rt[3:1] == 3'b000); // rt 0,1,16,17

    assign is_branch = (inst.i.opcode[5:2] == 4'b0001) || is_regimm_br;
    assign is_jump_i = (inst.j.opcode[5:1] == 5'b00001);
    assign is_jump_r = is_special && (inst.r.funct[5:1] == 5'b00100);

    assign is_call = (inst.j.opcode == 6'b000011)
                   || (is_special && inst.r.funct == 6'b001001)
                   || (is_regimm_br && inst.i.rt[4]); // link branches

    assign is_return = is_special && (inst.r.funct == 6'b001000)
                     && (inst.r.rs == `REG_ADDR_W'(`REG_RA));

    always_comb begin
        unique casez ({is_branch, is_return, is_call, is_jump_i | is_jump_r})
            4'b1???: cls.cf = decode_pkg::CF_BRANCH;
            4'b01??: cls.cf = decode_pkg::CF_RETURN;
            4'b001?: cls.cf = decode_pkg::CF_CALL;
            4'b0001: cls.cf = decode_pkg::CF_JUMP;
            default: cls.cf = decode_pkg::CF_NONE;
        endcase
    end

    assign cls.is_controlflow = is_branch | is_jump_i | is_jump_r;

endmodule

// File: target_calc.sv
// precomputes the PC-relative branch target and the region jump target of an instruction
`timescale 1ns/100ps
`include "mips_decode_macros.svh"

module target_calc (
    input decode_pkg::virt_t vaddr,
    input decode_pkg::inst_u inst,
    decode_if.tgt            tgt
);

    decode_pkg::virt_t pc_plus4;
    decode_pkg::virt_t br_offset;

    assign pc_plus4  = vaddr + `MIPS_XLEN'(`PC_STEP);
    assign br_offset = {{(`MIPS_XLEN - 18){inst.i.imm16[15]}}, inst.i.imm16, 2'b00}; // word offset

    assign tgt.jump_i = pc_plus4 + br_offset;
    // 256 MB region of the delay slot
    assign tgt.jump_j = {pc_plus4[`MIPS_XLEN-1 -: 4], inst.j.index26, 2'b00};

endmodule

// File: op_decoder.sv
// main opcode and funct decode into operation, register numbers and operand flags
`timescale 1ns/100ps
`include "mips_decode_macros.svh"

module op_decoder (
    input decode_pkg::inst_u inst,
    decode_if.dec            dec
);

    always_comb begin
        dec.rs1        = '0;
        dec.rs2        = '0;
        dec.rd         = '0;
        dec.op         = decode_pkg::OP_INVALID;
        dec.use_imm    = 1'b0;
        dec.imm_signed = 1'b1;
        dec.is_load    = 1'b0;
        dec.is_store   = 1'b0;

        unique casez (inst.r.opcode)
            6'b000000: begin // SPECIAL
                dec.rs1 = inst.r.rs;
                dec.rs2 = inst.r.rt;
                dec.rd  = inst.r.rd;
                unique case (inst.r.funct)
                    6'b000000: dec.op = decode_pkg::OP_SLL;
                    6'b000010: dec.op = decode_pkg::OP_SRL;
                    6'b000011: dec.op = decode_pkg::OP_SRA;
                    6'b000100: dec.op = decode_pkg::OP_SLLV;
                    6'b000110: dec.op = decode_pkg::OP_SRLV;
                    6'b000111: dec.op = decode_pkg::OP_SRAV;
                    6'b001000: dec.op = decode_pkg::OP_JALR; // JR shares the jump unit
                    6'b001001: dec.op = decode_pkg::OP_JALR;
                    6'b001100: dec.op = decode_pkg::OP_SYSCALL;
                    6'b001101: dec.op = decode_pkg::OP_BREAK;
                    6'b010000: dec.op = decode_pkg::OP_MFHI;
                    6'b010001: dec.op = decode_pkg::OP_MTHI;
                    6'b010010: dec.op = decode_pkg::OP_MFLO;
                    6'b010011: dec.op = decode_pkg::OP_MTLO;
                    6'b011000: dec.op = decode_pkg::OP_MULT;
                    6'b011001: dec.op = decode_pkg::OP_MULTU;
                    6'b011010: dec.op = decode_pkg::OP_DIV;
                    6'b011011: dec.op = decode_pkg::OP_DIVU;
                    6'b100000: dec.op = decode_pkg::OP_ADD;
                    6'b100001: dec.op = decode_pkg::OP_ADDU;
                    6'b100010: dec.op = decode_pkg::OP_SUB;
                    6'b100011: dec.op = decode_pkg::OP_SUBU;
                    6'b100100: dec.op = decode_pkg::OP_AND;
                    6'b100101: dec.op = decode_pkg::OP_OR;
                    6'b100110: dec.op = decode_pkg::OP_XOR;
                    6'b100111: dec.op = decode_pkg::OP_NOR;
                    6'b101010: dec.op = decode_pkg::OP_SLT;
                    6'b101011: dec.op = decode_pkg::OP_SLTU;
                    default:   dec.op = decode_pkg::OP_INVALID;
                endcase
            end

            6'b000001: begin // REGIMM
                dec.rs1     = inst.i.rs;
                dec.rd      = (inst.i.rt[4:1] == 4'b1000) ? `REG_ADDR_W'(`REG_RA) : '0;
                dec.use_imm = 1'b1;
                unique case (inst.i.rt)
                    5'b00000: dec.op = decode_pkg::OP_BLTZ;
                    5'b00001: dec.op = decode_pkg::OP_BGEZ;
                    5'b10000: dec.op = decode_pkg::OP_BLTZAL;
                    5'b10001: dec.op = decode_pkg::OP_BGEZAL;
                    default:  dec.op = decode_pkg::OP_INVALID;
                endcase
            end

            6'b0001??: begin // two-register branches
                dec.rs1 = inst.i.rs;
                dec.rs2 = inst.i.rt;
                unique case (inst.i.opcode[1:0])
                    2'b00: dec.op = decode_pkg::OP_BEQ;
                    2'b01: dec.op = decode_pkg::OP_BNE;
                    2'b10: dec.op = decode_pkg::OP_BLEZ;
                    2'b11: dec.op = decode_pkg::OP_BGTZ;
                endcase
            end

            6'b001???: begin // immediate alu
                dec.rs1        = inst.i.rs;
                dec.rd         = inst.i.rt;
                dec.use_imm    = 1'b1;
                dec.imm_signed = ~inst.i.opcode[2]; // logic ops zero-extend
                unique case (inst.i.opcode[2:0])
                    3'b000: dec.op = decode_pkg::OP_ADD;
                    3'b001: dec.op = decode_pkg::OP_ADDU;
                    3'b010: dec.op = decode_pkg::OP_SLT;
                    3'b011: dec.op = decode_pkg::OP_SLTU;
                    3'b100: dec.op = decode_pkg::OP_AND;
                    3'b101: dec.op = decode_pkg::OP_OR;
                    3'b110: dec.op = decode_pkg::OP_XOR;
                    3'b111: dec.op = decode_pkg::OP_LUI;
                endcase
            end

            6'b100???: begin // loads
                dec.rs1     = inst.i.rs;
                dec.rd      = inst.i.rt;
                dec.is_load = 1'b1;
                unique case (inst.i.opcode[2:0])
                    3'b000:  dec.op = decode_pkg::OP_LB;
                    3'b001:  dec.op = decode_pkg::OP_LH;
                    3'b011:  dec.op = decode_pkg::OP_LW;
                    3'b100:  dec.op = decode_pkg::OP_LBU;
                    3'b101:  dec.op = decode_pkg::OP_LHU;
                    default: dec.op = decode_pkg::OP_INVALID;
                endcase
            end

            6'b101???: begin // stores
                dec.rs1      = inst.i.rs;
                dec.rs2      = inst.i.rt;
                dec.is_store = 1'b1;
                unique case (inst.i.opcode[2:0])
                    3'b000:  dec.op = decode_pkg::OP_SB;
                    3'b001:  dec.op = decode_pkg::OP_SH;
                    3'b011:  dec.op = decode_pkg::OP_SW;
                    default: dec.op = decode_pkg::OP_INVALID;
                endcase
            end

            6'b00001?: begin // J and JAL
                dec.rd = inst.j.opcode[0] ? `REG_ADDR_W'(`REG_RA) : '0;
                dec.op = decode_pkg::OP_JAL;
            end

            6'b010000: begin // COP0
                unique case (inst.r.rs)
                    5'b00000: begin
                        dec.op = decode_pkg::OP_MFC0;
                        dec.rd = inst.r.rt;
                    end
                    5'b00100: begin
                        dec.op  = decode_pkg::OP_MTC0;
                        dec.rs1 = inst.r.rt;
                    end
                    5'b10000: begin
                        dec.op = (inst.r.funct == 6'b011000) ? decode_pkg::OP_ERET
                                                             : decode_pkg::OP_INVALID;
                    end
                    default: dec.op = decode_pkg::OP_INVALID;
                endcase
            end

            default: dec.op = decode_pkg::OP_INVALID;
        endcase
    end

endmodule

// File: decode_stage_reg.sv
// pipeline register that holds the decode response and its valid bit for one cycle
`timescale 1ns/100ps

module decode_stage_reg (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_valid,
    decode_if.sink                src,
    output logic                  resp_valid,
    output decode_pkg::op_t       resp_op,
    output decode_pkg::reg_addr_t resp_rs1,
    output decode_pkg::reg_addr_t resp_rs2,
    output decode_pkg::reg_addr_t resp_rd,
    output logic                  resp_use_imm,
    output logic                  resp_imm_signed,
    output logic                  resp_is_load,
    output logic                  resp_is_store,
    output logic                  resp_is_controlflow,
    output decode_pkg::cf_t       resp_cf,
    output decode_pkg::virt_t     resp_jump_i,
    output decode_pkg::virt_t     resp_jump_j
);

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid          <= 1'b0;
            resp_op             <= decode_pkg::OP_INVALID;
            resp_rs1            <= '0;
            resp_rs2            <= '0;
            resp_rd             <= '0;
            resp_use_imm        <= 1'b0;
            resp_imm_signed     <= 1'b0;
            resp_is_load        <= 1'b0;
            resp_is_store       <= 1'b0;
            resp_is_controlflow <= 1'b0;
            resp_cf             <= decode_pkg::CF_NONE;
            resp_jump_i         <= '0;
            resp_jump_j         <= '0;
        end else begin
            resp_valid <= inst_valid;
            if (inst_valid) begin // fields hold through gaps
                resp_op             <= src.op;
                resp_rs1            <= src.rs1;
                resp_rs2            <= src.rs2;
                resp_rd             <= src.rd;
                resp_use_imm        <= src.use_imm;
                resp_imm_signed     <= src.imm_signed;
                resp_is_load        <= src.is_load;
                resp_is_store       <= src.is_store;
                resp_is_controlflow <= src.is_controlflow;
                resp_cf             <= src.cf;
                resp_jump_i         <= src.jump_i;
                resp_jump_j         <= src.jump_j;
            end
        end
    end

endmodule

// File: mips_decoder.sv
// MIPS32 decode stage top level taking one instruction per strobe and answering a cycle later
`timescale 1ns/100ps
`include "mips_decode_macros.svh"

module mips_decoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_valid,
    input  decode_pkg::virt_t     vaddr,
    input  logic [`MIPS_XLEN-1:0] inst,
    output logic                  resp_valid,
    output decode_pkg::op_t       resp_op,
    output decode_pkg::reg_addr_t resp_rs1,
    output decode_pkg::reg_addr_t resp_rs2,
    output decode_pkg::reg_addr_t resp_rd,
    output logic                  resp_use_imm,
    output logic                  resp_imm_signed,
    output logic                  resp_is_load,
    output logic                  resp_is_store,
    output logic                  resp_is_controlflow,
    output decode_pkg::cf_t       resp_cf,
    output decode_pkg::virt_t     resp_jump_i,
    output decode_pkg::virt_t     resp_jump_j
);

    decode_pkg::inst_u inst_w;

    assign inst_w = decode_pkg::inst_u'(inst); // r/i/j views of the fetched word

    decode_if u_dif ();

    op_decoder u_op_decoder (
        .inst (inst_w),
        .dec  (u_dif)
    );

    branch_classifier u_branch_classifier (
        .inst (inst_w),
        .cls  (u_dif)
    );

    target_calc u_target_calc (
        .vaddr (vaddr),
        .inst  (inst_w),
        .tgt   (u_dif)
    );

    decode_stage_reg u_stage_reg (
        .clk                 (clk),
        .rst                 (rst),
        .inst_valid          (inst_valid),
        .src                 (u_dif),
        .resp_valid          (resp_valid),
        .resp_op             (resp_op),
        .resp_rs1            (resp_rs1),
        .resp_rs2            (resp_rs2),
        .resp_rd             (resp_rd),
        .resp_use_imm        (resp_use_imm),
        .resp_imm_signed     (resp_imm_signed),
        .resp_is_load        (resp_is_load),
        .resp_is_store       (resp_is_store),
        .resp_is_controlflow (resp_is_controlflow),
        .resp_cf             (resp_cf),
        .resp_jump_i         (resp_jump_i),
        .resp_jump_j         (resp_jump_j)
    );

endmodule

// File: tb_mips_decoder.sv
// self-checking testbench that feeds LCG instruction words to the decode stage against a model
`timescale 1ns/100ps
`include "mips_decode_macros.svh"

module tb_mips_decoder;

    localparam int RESET_CYCLES = 10;
    localparam int NUM_VECTORS  = 2280;
    localparam int MAX_CYCLES   = (RESET_CYCLES + NUM_VECTORS) * 13 / 10; // 30% margin

    typedef struct packed {
        logic                  valid;
        decode_pkg::op_t       op;
        decode_pkg::reg_addr_t rs1;
        decode_pkg::reg_addr_t rs2;
        decode_pkg::reg_addr_t rd;
        logic                  use_imm;
        logic                  imm_signed;
        logic                  is_load;
        logic                  is_store;
        logic                  is_cf;
        decode_pkg::cf_t       cf;
        decode_pkg::virt_t     jump_i;
        decode_pkg::virt_t     jump_j;
    } resp_t;

    logic                  clk;
    logic                  rst;
    logic                  inst_valid;
    decode_pkg::virt_t     vaddr;
    logic [`MIPS_XLEN-1:0] inst;
    logic                  resp_valid;
    decode_pkg::op_t       resp_op;
    decode_pkg::reg_addr_t resp_rs1;
    decode_pkg::reg_addr_t resp_rs2;
    decode_pkg::reg_addr_t resp_rd;
    logic                  resp_use_imm;
    logic                  resp_imm_signed;
    logic                  resp_is_load;
    logic                  resp_is_store;
    logic                  resp_is_controlflow;
    decode_pkg::cf_t       resp_cf;
    decode_pkg::virt_t     resp_jump_i;
    decode_pkg::virt_t     resp_jump_j;

    logic [31:0] lcg_state;
    int          cycles = 0;
    resp_t       exp_q[$];
    string       name_q[$];
    string       class_names[10] = '{"special", "jr_jalr", "regimm", "branch", "imm_alu",
                                     "load", "store", "jump", "cop0", "undefined"};

    mips_decoder u_dut (
        .clk                 (clk),
        .rst                 (rst),
        .inst_valid          (inst_valid),
        .vaddr               (vaddr),
        .inst                (inst),
        .resp_valid          (resp_valid),
        .resp_op             (resp_op),
        .resp_rs1            (resp_rs1),
        .resp_rs2            (resp_rs2),
        .resp_rd             (resp_rd),
        .resp_use_imm        (resp_use_imm),
        .resp_imm_signed     (resp_imm_signed),
        .resp_is_load        (resp_is_load),
        .resp_is_store       (resp_is_store),
        .resp_is_controlflow (resp_is_controlflow),
        .resp_cf             (resp_cf),
        .resp_jump_i         (resp_jump_i),
        .resp_jump_j         (resp_jump_j)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] a;
        logic [31:0] b;
        a = lcg_step();
        b = lcg_step(); // upper halves of two steps
        return {a[31:16], b[31:16]};
    endfunction

    function automatic decode_pkg::op_t special_op(input logic [5:0] fn);
        case (fn)
            6'h00:   return decode_pkg::OP_SLL;
            6'h02:   return decode_pkg::OP_SRL;
            6'h03:   return decode_pkg::OP_SRA;
            6'h04:   return decode_pkg::OP_SLLV;
            6'h06:   return decode_pkg::OP_SRLV;
            6'h07:   return decode_pkg::OP_SRAV;
            6'h08:   return decode_pkg::OP_JALR; // JR reported as the jump-register op
            6'h09:   return decode_pkg::OP_JALR;
            6'h0c:   return decode_pkg::OP_SYSCALL;
            6'h0d:   return decode_pkg::OP_BREAK;
            6'h10:   return decode_pkg::OP_MFHI;
            6'h11:   return decode_pkg::OP_MTHI;
            6'h12:   return decode_pkg::OP_MFLO;
            6'h13:   return decode_pkg::OP_MTLO;
            6'h18:   return decode_pkg::OP_MULT;
            6'h19:   return decode_pkg::OP_MULTU;
            6'h1a:   return decode_pkg::OP_DIV;
            6'h1b:   return decode_pkg::OP_DIVU;
            6'h20:   return decode_pkg::OP_ADD;
            6'h21:   return decode_pkg::OP_ADDU;
            6'h22:   return decode_pkg::OP_SUB;
            6'h23:   return decode_pkg::OP_SUBU;
            6'h24:   return decode_pkg::OP_AND;
            6'h25:   return decode_pkg::OP_OR;
            6'h26:   return decode_pkg::OP_XOR;
            6'h27:   return decode_pkg::OP_NOR;
            6'h2a:   return decode_pkg::OP_SLT;
            6'h2b:   return decode_pkg::OP_SLTU;
            default: return decode_pkg::OP_INVALID;
        endcase
    endfunction

    // expected response of one accepted instruction
    function automatic resp_t decode_model(input logic [31:0] w, input decode_pkg::virt_t pc);
        resp_t             e;
        logic [5:0]        opc;
        logic [4:0]        rs;
        logic [4:0]        rt;
        logic [5:0]        fn;
        logic              regimm_br;
        logic              branch;
        logic              jump;
        logic              call;
        logic              ret;
        decode_pkg::virt_t pc4;
        opc          = w[31:26];
        rs           = w[25:21];
        rt           = w[20:16];
        fn           = w[5:0];
        e            = '0;
        e.valid      = 1'b1;
        e.op         = decode_pkg::OP_INVALID;
        e.imm_signed = 1'b1;
        case (opc) inside
            6'h00: begin
                e.rs1 = rs;
                e.rs2 = rt;
                e.rd  = w[15:11];
                e.op  = special_op(fn);
            end
            6'h01: begin
                e.rs1     = rs;
                e.use_imm = 1'b1;
                if (rt == 5'd16 || rt == 5'd17) begin
                    e.rd = `REG_ADDR_W'(`REG_RA);
                end
                case (rt)
                    5'd0:    e.op = decode_pkg::OP_BLTZ;
                    5'd1:    e.op = decode_pkg::OP_BGEZ;
                    5'd16:   e.op = decode_pkg::OP_BLTZAL;
                    5'd17:   e.op = decode_pkg::OP_BGEZAL;
                    default: e.op = decode_pkg::OP_INVALID;
                endcase
            end
            6'h02, 6'h03: begin
                e.op = decode_pkg::OP_JAL;
                if (opc == 6'h03) begin
                    e.rd = `REG_ADDR_W'(`REG_RA);
                end
            end
            [6'h04:6'h07]: begin
                e.rs1 = rs;
                e.rs2 = rt;
                case (opc)
                    6'h04:   e.op = decode_pkg::OP_BEQ;
                    6'h05:   e.op = decode_pkg::OP_BNE;
                    6'h06:   e.op = decode_pkg::OP_BLEZ;
                    default: e.op = decode_pkg::OP_BGTZ;
                endcase
            end
            [6'h08:6'h0f]: begin
                e.rs1        = rs;
                e.rd         = rt;
                e.use_imm    = 1'b1;
                e.imm_signed = (opc < 6'h0c); // ANDI ORI XORI LUI zero-extend
                case (opc)
                    6'h08:   e.op = decode_pkg::OP_ADD;
                    6'h09:   e.op = decode_pkg::OP_ADDU;
                    6'h0a:   e.op = decode_pkg::OP_SLT;
                    6'h0b:   e.op = decode_pkg::OP_SLTU;
                    6'h0c:   e.op = decode_pkg::OP_AND;
                    6'h0d:   e.op = decode_pkg::OP_OR;
                    6'h0e:   e.op = decode_pkg::OP_XOR;
                    default: e.op = decode_pkg::OP_LUI;
                endcase
            end
            6'h10: begin
                if (rs == 5'd0) begin
                    e.op = decode_pkg::OP_MFC0;
                    e.rd = rt;
                end else if (rs == 5'd4) begin
                    e.op  = decode_pkg::OP_MTC0;
                    e.rs1 = rt;
                end else if (rs == 5'd16 && fn == 6'h18) begin
                    e.op = decode_pkg::OP_ERET;
                end
            end
            [6'h20:6'h27]: begin
                e.rs1     = rs;
                e.rd      = rt;
                e.is_load = 1'b1;
                case (opc)
                    6'h20:   e.op = decode_pkg::OP_LB;
                    6'h21:   e.op = decode_pkg::OP_LH;
                    6'h23:   e.op = decode_pkg::OP_LW;
                    6'h24:   e.op = decode_pkg::OP_LBU;
                    6'h25:   e.op = decode_pkg::OP_LHU;
                    default: e.op = decode_pkg::OP_INVALID;
                endcase
            end
            [6'h28:6'h2f]: begin
                e.rs1      = rs;
                e.rs2      = rt;
                e.is_store = 1'b1;
                case (opc)
                    6'h28:   e.op = decode_pkg::OP_SB;
                    6'h29:   e.op = decode_pkg::OP_SH;
                    6'h2b:   e.op = decode_pkg::OP_SW;
                    default: e.op = decode_pkg::OP_INVALID;
                endcase
            end
            default: ;
        endcase

        regimm_br = (opc == 6'h01) && (rt == 5'd0 || rt == 5'd1 || rt == 5'd16 || rt == 5'd17);
        branch    = (opc >= 6'h04 && opc <= 6'h07) || regimm_br;
        jump      = (opc == 6'h02) || (opc == 6'h03)
                  || (opc == 6'h00 && (fn == 6'h08 || fn == 6'h09));
        call      = (opc == 6'h03) || (opc == 6'h00 && fn == 6'h09) || (regimm_br && rt[4]);
        ret       = (opc == 6'h00) && (fn == 6'h08) && (rs == `REG_ADDR_W'(`REG_RA));
        e.is_cf   = branch | jump;
        if (branch) begin
            e.cf = decode_pkg::CF_BRANCH;
        end else if (ret) begin
            e.cf = decode_pkg::CF_RETURN;
        end else if (call) begin
            e.cf = decode_pkg::CF_CALL;
        end else if (jump) begin
            e.cf = decode_pkg::CF_JUMP;
        end else begin
            e.cf = decode_pkg::CF_NONE;
        end
        pc4      = pc + 32'(`PC_STEP);
        e.jump_i = pc4 + (32'($signed(w[15:0])) << 2);
        e.jump_j = (pc4 & 32'hf000_0000) | (32'(w[25:0]) << 2);
        return e;
    endfunction

    // random word of one instruction class
    function automatic logic [31:0] make_inst(input int cls);
        logic [31:0] w;
        logic [31:0] r;
        w = rand_word();
        r = rand_word();
        case (cls)
            0: w[31:26] = 6'h00;
            1: begin
                w[31:26] = 6'h00;
                w[5:0]   = {5'b00100, r[0]}; // JR or JALR
                if (r[1]) begin
                    w[25:21] = 5'd31;
                end
            end
            2: begin
                w[31:26] = 6'h01;
                if (r[2]) begin
                    w[20:16] = {r[3], 3'b000, r[4]}; // rt 0, 1, 16 or 17
                end
            end
            3: w[31:28] = 4'b0001;
            4: w[31:29] = 3'b001;
            5: w[31:29] = 3'b100;
            6: w[31:29] = 3'b101;
            7: w[31:27] = 5'b00001;
            8: begin
                w[31:26] = 6'h10;
                case (r[1:0])
                    2'd0:    w[25:21] = 5'd0;
                    2'd1:    w[25:21] = 5'd4;
                    2'd2:    w[25:21] = 5'd16;
                    default: ;
                endcase
                if (r[2]) begin
                    w[5:0] = 6'h18;
                end
            end
            default: w[31:26] = r[3] ? 6'd17 + 6'(r[7:4] % 4'd15) : 6'd48 + 6'(r[7:4]);
        endcase
        return w;
    endfunction

    task automatic abort_run(input string reason);
        $display("TEST FAILED");
        $fatal(1, reason);
    endtask

    task automatic check_op(input string name, input decode_pkg::op_t exp,
                            input decode_pkg::op_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %s, actual %s", name, exp.name(), act.name());
            abort_run("operation mismatch");
        end
    endtask

    task automatic check_reg(input string name, input decode_pkg::reg_addr_t exp,
                             input decode_pkg::reg_addr_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            abort_run("register number mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            abort_run("flag mismatch");
        end
    endtask

    task automatic check_cf(input string name, input decode_pkg::cf_t exp,
                            input decode_pkg::cf_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %s, actual %s", name, exp.name(), act.name());
            abort_run("control-flow class mismatch");
        end
    endtask

    task automatic check_addr(input string name, input decode_pkg::virt_t exp,
                              input decode_pkg::virt_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            abort_run("target address mismatch");
        end
    endtask

    task automatic check_resp(input string name, input resp_t e);
        check_flag({name, " valid"}, e.valid, resp_valid);
        check_op({name, " op"}, e.op, resp_op);
        check_reg({name, " rs1"}, e.rs1, resp_rs1);
        check_reg({name, " rs2"}, e.rs2, resp_rs2);
        check_reg({name, " rd"}, e.rd, resp_rd);
        check_flag({name, " use_imm"}, e.use_imm, resp_use_imm);
        check_flag({name, " imm_signed"}, e.imm_signed, resp_imm_signed);
        check_flag({name, " is_load"}, e.is_load, resp_is_load);
        check_flag({name, " is_store"}, e.is_store, resp_is_store);
        check_flag({name, " is_controlflow"}, e.is_cf, resp_is_controlflow);
        check_cf({name, " cf"}, e.cf, resp_cf);
        check_addr({name, " jump_i"}, e.jump_i, resp_jump_i);
        check_addr({name, " jump_j"}, e.jump_j, resp_jump_j);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run went past %0d cycles", MAX_CYCLES);
            abort_run("cycle limit reached");
        end
    end

    initial begin
        resp_t             e;
        resp_t             held;
        logic              v;
        int                cls;
        decode_pkg::virt_t pc;
        logic [31:0]       w;
        lcg_state  = 32'h46d7;
        rst        = 1'b1;
        inst_valid = 1'b0;
        vaddr      = '0;
        inst       = '0;
        held       = '0;
        held.op    = decode_pkg::OP_INVALID; // register contents after reset

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_flag("reset valid", 1'b0, resp_valid);
            check_op("reset op", decode_pkg::OP_INVALID, resp_op);
        end
        rst = 1'b0;
        exp_q.push_back(held);
        name_q.push_back("after reset");

        for (int n = 0; n < NUM_VECTORS; n++) begin
            @(posedge clk);
            #1;
            check_resp(name_q.pop_front(), exp_q.pop_front());
            cls        = int'((lcg_step() >> 16) % 32'd10);
            v          = ((lcg_step() >> 16) % 32'd4) != 0; // about one gap in four
            pc         = rand_word() & ~32'h3;
            w          = make_inst(cls);
            inst_valid = v;
            vaddr      = pc;
            inst       = w;
            if (v) begin
                held = decode_model(w, pc);
                name_q.push_back(class_names[cls[3:0]]);
            end else begin
                name_q.push_back("valid gap"); // fields must hold
            end
            e       = held;
            e.valid = v;
            exp_q.push_back(e);
        end

        @(posedge clk);
        #1;
        check_resp(name_q.pop_front(), exp_q.pop_front());
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+.
decode_pkg.sv
decode_if.sv
branch_classifier.sv
target_calc.sv
op_decoder.sv
decode_stage_reg.sv
mips_decoder.sv
tb_mips_decoder.sv

// File: Makefile
TOOL       := verilator
TOP        := tb_mips_decoder
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --top-module $(TOP)

.PHONY: all lint clean

all:
	$(TOOL) $(FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
